/* include/t6502_cfg.svh */
`ifndef T6502_CFG_SVH
`define T6502_CFG_SVH

// Register and data byte width
`define T6502_DATA_W    8

// Stack pointer comes up at the top of page one
`define T6502_SP_RESET  8'hFF

// I flag and the unused bit 5 set after reset
`define T6502_PSR_RESET 8'h24

// PSR bit positions
`define PSR_C 3'd0
`define PSR_Z 3'd1
`define PSR_I 3'd2
`define PSR_D 3'd3
`define PSR_V 3'd6
`define PSR_N 3'd7

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the t6502_seq testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module t6502_seq_tb -Mdir "$BUILD_DIR" -o t6502_seq_sim \
    -f t6502_seq.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/t6502_seq_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG_FILE"; then
    echo "Simulation reported failures, see $LOG_FILE"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

/* src/execute_unit.sv */
`default_nettype none

`include "t6502_cfg.svh"

module execute_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     exec_en,
    input  t6502_pkg::alu_op_e       alu_op,
    input  t6502_pkg::src_sel_e      src_sel,
    input  t6502_pkg::b_sel_e        b_sel,
    input  t6502_pkg::cin_sel_e      cin_sel,
    input  t6502_pkg::dst_sel_e      dst_sel,
    input  logic                     upd_nz,
    input  logic                     upd_c,
    input  logic                     upd_v,
    input  logic                     psr_bit_en,
    input  logic [2:0]               psr_bit_sel,
    input  logic                     psr_bit_val,
    input  logic [`T6502_DATA_W-1:0] operand,
    output logic                     done,
    output logic [`T6502_DATA_W-1:0] acc,
    output logic [`T6502_DATA_W-1:0] idx_x,
    output logic [`T6502_DATA_W-1:0] idx_y,
    output logic [`T6502_DATA_W-1:0] sp,
    output logic [`T6502_DATA_W-1:0] psr
);
    import t6502_pkg::*;

    localparam int W = `T6502_DATA_W;

    logic [W-1:0] op_a;
    logic [W-1:0] op_b;
    logic         cin;
    logic [W:0]   sum;
    logic [W-1:0] alu_res;
    logic         alu_cout;
    logic         alu_ovf;
    logic [W-1:0] psr_next;

    // Operand selects
    always_comb begin
        case (src_sel)
            SRC_X:   op_a = idx_x;
            SRC_Y:   op_a = idx_y;
            SRC_SP:  op_a = sp;
            default: op_a = acc;
        endcase
    end

    always_comb begin
        case (b_sel)
            B_ONES:  op_b = '1;
            B_SAME:  op_b = op_a;
            B_IMM:   op_b = operand;
            default: op_b = '0;
        endcase
    end

    always_comb begin
        case (cin_sel)
            CIN_ONE: cin = 1'b1;
            CIN_PSR: cin = psr[`PSR_C];
            default: cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, op_a} + {1'b0, op_b} + {{W{1'b0}}, cin};

    always_comb begin
        alu_cout = 1'b0;
        alu_ovf  = 1'b0;
        case (alu_op)
            ALU_AND: alu_res = op_a & op_b;
            // Carry-in enters at bit 7, bit 0 leaves as carry
            ALU_SHR: begin
                alu_res  = {cin, op_a[W-1:1]};
                alu_cout = op_a[0];
            end
            default: begin
                alu_res  = sum[W-1:0];
                alu_cout = sum[W];
                // Overflow when like-signed operands give a different sign
                alu_ovf  = (op_a[W-1] == op_b[W-1]) && (sum[W-1] != op_a[W-1]);
            end
        endcase
    end

    always_comb begin
        psr_next = psr;
        if (upd_nz) begin
            psr_next[`PSR_N] = alu_res[W-1];
            psr_next[`PSR_Z] = (alu_res == '0);
        end
        if (upd_c) begin
            psr_next[`PSR_C] = alu_cout;
        end
        if (upd_v) begin
            psr_next[`PSR_V] = alu_ovf;
        end
        if (psr_bit_en) begin
            psr_next[psr_bit_sel] = psr_bit_val;
        end
    end

    // Register file and PSR, written at the end of T1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc   <= '0;
            idx_x <= '0;
            idx_y <= '0;
            sp    <= `T6502_SP_RESET;
            psr   <= `T6502_PSR_RESET;
            done  <= 1'b0;
        end else begin
            done <= exec_en;
            if (exec_en) begin
                case (dst_sel)
                    DST_ACC: acc <= alu_res;
                    DST_X:   idx_x <= alu_res;
                    DST_Y:   idx_y <= alu_res;
                    DST_SP:  sp <= alu_res;
                    default: ;
                endcase
                psr <= psr_next;
            end
        end
    end

endmodule

`default_nettype wire

/* src/opcode_decoder.sv */
`default_nettype none

`include "t6502_cfg.svh"

module opcode_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [`T6502_DATA_W-1:0] opcode,
    output logic                     exec_en,
    output t6502_pkg::alu_op_e       alu_op,
    output t6502_pkg::src_sel_e      src_sel,
    output t6502_pkg::b_sel_e        b_sel,
    output t6502_pkg::cin_sel_e      cin_sel,
    output t6502_pkg::dst_sel_e      dst_sel,
    output logic                     upd_nz,
    output logic                     upd_c,
    output logic                     upd_v,
    output logic                     psr_bit_en,
    output logic [2:0]               psr_bit_sel,
    output logic                     psr_bit_val
);
    import t6502_pkg::*;

    seq_state_e               state;
    logic [`T6502_DATA_W-1:0] op_q;

    alu_op_e  alu_op_d;
    src_sel_e src_sel_d;
    b_sel_e   b_sel_d;
    cin_sel_e cin_sel_d;
    dst_sel_e dst_sel_d;
    logic     upd_nz_d;
    logic     upd_c_d;
    logic     upd_v_d;
    logic     psr_bit_en_d;
    logic [2:0] psr_bit_sel_d;
    logic     psr_bit_val_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= start ? T0 : IDLE;
                T0:      state <= T1;
                default: state <= IDLE;
            endcase
        end
    end

    // Opcode captured as the sequencer leaves IDLE
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            op_q <= opcode;
        end
    end

    // T0 decode, defaults form the inactive word
    always_comb begin
        alu_op_d      = ALU_ADD;
        src_sel_d     = SRC_ACC;
        b_sel_d       = B_ZERO;
        cin_sel_d     = CIN_ZERO;
        dst_sel_d     = DST_NONE;
        upd_c_d       = 1'b0;
        upd_v_d       = 1'b0;
        psr_bit_en_d  = 1'b0;
        psr_bit_sel_d = `PSR_C;
        psr_bit_val_d = 1'b0;
        case (opcode_e'(op_q))
            // Bit 6 picks right shifts, bit 5 rotates through carry
            OP_ASL, OP_ROL, OP_LSR, OP_ROR: begin
                alu_op_d  = op_q[6] ? ALU_SHR : ALU_ADD;
                cin_sel_d = op_q[5] ? CIN_PSR : CIN_ZERO;
                b_sel_d   = B_SAME;
                dst_sel_d = DST_ACC;
                upd_c_d   = 1'b1;
            end
            OP_INX: begin
                src_sel_d = SRC_X;
                cin_sel_d = CIN_ONE;
                dst_sel_d = DST_X;
            end
            OP_INY: begin
                src_sel_d = SRC_Y;
                cin_sel_d = CIN_ONE;
                dst_sel_d = DST_Y;
            end
            // Decrement as add of all ones
            OP_DEX: begin
                src_sel_d = SRC_X;
                b_sel_d   = B_ONES;
                dst_sel_d = DST_X;
            end
            OP_DEY: begin
                src_sel_d = SRC_Y;
                b_sel_d   = B_ONES;
                dst_sel_d = DST_Y;
            end
            OP_TAX: dst_sel_d = DST_X;
            OP_TAY: dst_sel_d = DST_Y;
            OP_TXA: begin
                src_sel_d = SRC_X;
                dst_sel_d = DST_ACC;
            end
            OP_TYA: begin
                src_sel_d = SRC_Y;
                dst_sel_d = DST_ACC;
            end
            OP_TSX: begin
                src_sel_d = SRC_SP;
                dst_sel_d = DST_X;
            end
            OP_TXS: begin
                src_sel_d = SRC_X;
                dst_sel_d = DST_SP;
            end
            OP_NOP: ;
            // Opcode bit 5 is the new flag value for the set/clear pairs
            OP_SEC, OP_CLC: begin
                psr_bit_en_d  = 1'b1;
                psr_bit_sel_d = `PSR_C;
                psr_bit_val_d = op_q[5];
            end
            OP_SED, OP_CLD: begin
                psr_bit_en_d  = 1'b1;
                psr_bit_sel_d = `PSR_D;
                psr_bit_val_d = op_q[5];
            end
            OP_SEI, OP_CLI: begin
                psr_bit_en_d  = 1'b1;
                psr_bit_sel_d = `PSR_I;
                psr_bit_val_d = op_q[5];
            end
            OP_CLV: begin
                psr_bit_en_d  = 1'b1;
                psr_bit_sel_d = `PSR_V;
            end
            // Binary mode only, D is not looked at
            OP_ADC: begin
                b_sel_d   = B_IMM;
                cin_sel_d = CIN_PSR;
                dst_sel_d = DST_ACC;
                upd_c_d   = 1'b1;
                upd_v_d   = 1'b1;
            end
            OP_AND: begin
                alu_op_d  = ALU_AND;
                b_sel_d   = B_IMM;
                dst_sel_d = DST_ACC;
            end
            default: ;
        endcase
        // Every write to A, X or Y sets N and Z, TXS leaves the flags alone
        upd_nz_d = (dst_sel_d != DST_NONE) && (dst_sel_d != DST_SP);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_op      <= ALU_ADD;
            src_sel     <= SRC_ACC;
            b_sel       <= B_ZERO;
            cin_sel     <= CIN_ZERO;
            dst_sel     <= DST_NONE;
            upd_nz      <= 1'b0;
            upd_c       <= 1'b0;
            upd_v       <= 1'b0;
            psr_bit_en  <= 1'b0;
            psr_bit_sel <= `PSR_C;
            psr_bit_val <= 1'b0;
        end else if (state == T0) begin
            alu_op      <= alu_op_d;
            src_sel     <= src_sel_d;
            b_sel       <= b_sel_d;
            cin_sel     <= cin_sel_d;
            dst_sel     <= dst_sel_d;
            upd_nz      <= upd_nz_d;
            upd_c       <= upd_c_d;
            upd_v       <= upd_v_d;
            psr_bit_en  <= psr_bit_en_d;
            psr_bit_sel <= psr_bit_sel_d;
            psr_bit_val <= psr_bit_val_d;
        end
    end

    assign exec_en = (state == T1);

endmodule

`default_nettype wire

/* src/result_port.sv */
`default_nettype none

`include "t6502_cfg.svh"

module result_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic                     done,
    input  logic [`T6502_DATA_W-1:0] acc_in,
    input  logic [`T6502_DATA_W-1:0] x_in,
    input  logic [`T6502_DATA_W-1:0] y_in,
    input  logic [`T6502_DATA_W-1:0] sp_in,
    input  logic [`T6502_DATA_W-1:0] psr_in,
    output logic                     start,
    output logic                     ack,
    output logic [`T6502_DATA_W-1:0] acc,
    output logic [`T6502_DATA_W-1:0] idx_x,
    output logic [`T6502_DATA_W-1:0] idx_y,
    output logic [`T6502_DATA_W-1:0] sp,
    output logic [`T6502_DATA_W-1:0] psr
);
    typedef enum logic [1:0] {PORT_IDLE, PORT_BUSY, PORT_ACK} port_state_e;

    port_state_e state;

    // Start lasts one cycle since the FSM leaves idle on the same edge
    assign start = (state == PORT_IDLE) && req;
    assign ack   = (state == PORT_ACK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_IDLE: state <= req ? PORT_BUSY : PORT_IDLE;
                PORT_BUSY: state <= done ? PORT_ACK : PORT_BUSY;
                PORT_ACK:  state <= req ? PORT_ACK : PORT_IDLE;
                default:   state <= PORT_IDLE;
            endcase
        end
    end

    // Visible registers only move when ack rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc   <= '0;
            idx_x <= '0;
            idx_y <= '0;
            sp    <= `T6502_SP_RESET;
            psr   <= `T6502_PSR_RESET;
        end else if (done) begin
            acc   <= acc_in;
            idx_x <= x_in;
            idx_y <= y_in;
            sp    <= sp_in;
            psr   <= psr_in;
        end
    end

endmodule

`default_nettype wire

/* src/t6502_pkg.sv */
`default_nettype none

`include "t6502_cfg.svh"

package t6502_pkg;

    // Kept opcodes, real 6502 encodings
    typedef enum logic [`T6502_DATA_W-1:0] {
        OP_ASL = 8'h0A,
        OP_ROL = 8'h2A,
        OP_LSR = 8'h4A,
        OP_ROR = 8'h6A,
        OP_INX = 8'hE8,
        OP_INY = 8'hC8,
        OP_DEX = 8'hCA,
        OP_DEY = 8'h88,
        OP_TAX = 8'hAA,
        OP_TAY = 8'hA8,
        OP_TXA = 8'h8A,
        OP_TYA = 8'h98,
        OP_TSX = 8'hBA,
        OP_TXS = 8'h9A,
        OP_NOP = 8'hEA,
        OP_SEC = 8'h38,
        OP_CLC = 8'h18,
        OP_SED = 8'hF8,
        OP_CLD = 8'hD8,
        OP_SEI = 8'h78,
        OP_CLI = 8'h58,
        OP_CLV = 8'hB8,
        OP_ADC = 8'h69,
        OP_AND = 8'h29
    } opcode_e;

    // Decoder T-states
    typedef enum logic [1:0] {IDLE, T0, T1} seq_state_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_AND, ALU_SHR} alu_op_e;

    // A operand source
    typedef enum logic [2:0] {SRC_ACC, SRC_X, SRC_Y, SRC_SP} src_sel_e;

    // B operand, B_SAME repeats the A operand for ASL and ROL
    typedef enum logic [1:0] {B_ZERO, B_ONES, B_SAME, B_IMM} b_sel_e;

    typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_PSR} cin_sel_e;

    // Register written at the end of T1
    typedef enum logic [2:0] {DST_NONE, DST_ACC, DST_X, DST_Y, DST_SP} dst_sel_e;

endpackage

`default_nettype wire

/* src/t6502_seq.sv */
`default_nettype none

`include "t6502_cfg.svh"

module t6502_seq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic [`T6502_DATA_W-1:0] opcode,
    input  logic [`T6502_DATA_W-1:0] operand,
    output logic                     ack,
    output logic [`T6502_DATA_W-1:0] acc,
    output logic [`T6502_DATA_W-1:0] idx_x,
    output logic [`T6502_DATA_W-1:0] idx_y,
    output logic [`T6502_DATA_W-1:0] sp,
    output logic [`T6502_DATA_W-1:0] psr
);
    import t6502_pkg::*;

    logic     start;
    logic     exec_en;
    logic     done;
    alu_op_e  alu_op;
    src_sel_e src_sel;
    b_sel_e   b_sel;
    cin_sel_e cin_sel;
    dst_sel_e dst_sel;
    logic     upd_nz;
    logic     upd_c;
    logic     upd_v;
    logic     psr_bit_en;
    logic [2:0] psr_bit_sel;
    logic     psr_bit_val;

    // Live register file, before the result latch
    logic [`T6502_DATA_W-1:0] acc_q;
    logic [`T6502_DATA_W-1:0] x_q;
    logic [`T6502_DATA_W-1:0] y_q;
    logic [`T6502_DATA_W-1:0] sp_q;
    logic [`T6502_DATA_W-1:0] psr_q;

    opcode_decoder opcode_decoder_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .opcode      (opcode),
        .exec_en     (exec_en),
        .alu_op      (alu_op),
        .src_sel     (src_sel),
        .b_sel       (b_sel),
        .cin_sel     (cin_sel),
        .dst_sel     (dst_sel),
        .upd_nz      (upd_nz),
        .upd_c       (upd_c),
        .upd_v       (upd_v),
        .psr_bit_en  (psr_bit_en),
        .psr_bit_sel (psr_bit_sel),
        .psr_bit_val (psr_bit_val)
    );

    execute_unit execute_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .exec_en     (exec_en),
        .alu_op      (alu_op),
        .src_sel     (src_sel),
        .b_sel       (b_sel),
        .cin_sel     (cin_sel),
        .dst_sel     (dst_sel),
        .upd_nz      (upd_nz),
        .upd_c       (upd_c),
        .upd_v       (upd_v),
        .psr_bit_en  (psr_bit_en),
        .psr_bit_sel (psr_bit_sel),
        .psr_bit_val (psr_bit_val),
        .operand     (operand),
        .done        (done),
        .acc         (acc_q),
        .idx_x       (x_q),
        .idx_y       (y_q),
        .sp          (sp_q),
        .psr         (psr_q)
    );

    result_port result_port_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .done   (done),
        .acc_in (acc_q),
        .x_in   (x_q),
        .y_in   (y_q),
        .sp_in  (sp_q),
        .psr_in (psr_q),
        .start  (start),
        .ack    (ack),
        .acc    (acc),
        .idx_x  (idx_x),
        .idx_y  (idx_y),
        .sp     (sp),
        .psr    (psr)
    );

endmodule

`default_nettype wire

/* t6502_seq.f */
+incdir+include
src/t6502_pkg.sv
src/opcode_decoder.sv
src/execute_unit.sv
src/result_port.sv
src/t6502_seq.sv
tests/t6502_seq_checker.sv
tests/t6502_seq_tb.sv

/* tests/t6502_seq_checker.sv */
`default_nettype none

`include "t6502_cfg.svh"

module t6502_seq_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     req,
    input logic                     start,
    input logic                     ack,
    input logic [`T6502_DATA_W-1:0] acc,
    input logic [`T6502_DATA_W-1:0] idx_x,
    input logic [`T6502_DATA_W-1:0] idx_y,
    input logic [`T6502_DATA_W-1:0] sp,
    input logic [`T6502_DATA_W-1:0] psr
);
    timeunit 1ns;
    timeprecision 1ps;

    ack_low_in_reset: assert property (@(posedge clk) !rst_n |-> !ack)
        else $error("ack is high while reset is asserted");

    // Start at edge k gives ack after edge k+3, seen in sampled values at k+4
    ack_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start, 4) |-> $rose(ack))
        else $error("ack did not rise three edges after start");

    ack_only_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(start, 4))
        else $error("ack rose without a start three edges earlier");

    // Latched registers frozen for the whole acknowledged phase
    outputs_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(acc) && $stable(idx_x) && $stable(idx_y)
            && $stable(sp) && $stable(psr))
        else $error("outputs changed while ack was high");

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else $error("ack rose while req was low");

endmodule

bind t6502_seq t6502_seq_checker t6502_seq_checker_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .start (start),
    .ack   (ack),
    .acc   (acc),
    .idx_x (idx_x),
    .idx_y (idx_y),
    .sp    (sp),
    .psr   (psr)
);

`default_nettype wire

/* tests/t6502_seq_tb.sv */
`default_nettype none

`include "t6502_cfg.svh"

module t6502_seq_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import t6502_pkg::*;

    localparam int RAND_TXN    = 400;
    localparam int UNKNOWN_TXN = 50;
    // A zero-hold handshake takes seven cycles, ten covers holds and the directed runs
    localparam int MAX_CYCLES  = (RAND_TXN + UNKNOWN_TXN) * 10 + 100;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     req;
    logic [`T6502_DATA_W-1:0] opcode;
    logic [`T6502_DATA_W-1:0] operand;
    logic                     ack;
    logic [`T6502_DATA_W-1:0] acc;
    logic [`T6502_DATA_W-1:0] idx_x;
    logic [`T6502_DATA_W-1:0] idx_y;
    logic [`T6502_DATA_W-1:0] sp;
    logic [`T6502_DATA_W-1:0] psr;

    // Reference model of the programmer-visible state
    logic [7:0] m_acc;
    logic [7:0] m_x;
    logic [7:0] m_y;
    logic [7:0] m_sp;
    logic [7:0] m_psr;

    logic [31:0] rng_state = 32'h23c;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    opcode_e kept_ops [24] = '{
        OP_ASL, OP_ROL, OP_LSR, OP_ROR, OP_INX, OP_INY, OP_DEX, OP_DEY,
        OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS, OP_NOP, OP_SEC,
        OP_CLC, OP_SED, OP_CLD, OP_SEI, OP_CLI, OP_CLV, OP_ADC, OP_AND
    };

    always #5 clk = ~clk;

    t6502_seq t6502_seq_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .opcode  (opcode),
        .operand (operand),
        .ack     (ack),
        .acc     (acc),
        .idx_x   (idx_x),
        .idx_y   (idx_y),
        .sp      (sp),
        .psr     (psr)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic is_kept(input logic [7:0] op);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 24; i++) begin
            if (kept_ops[i] == op) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic set_nz(input logic [7:0] value);
        m_psr[`PSR_N] = value[7];
        m_psr[`PSR_Z] = (value == 8'h00);
    endtask

    // Standard 6502 semantics, binary mode only
    task automatic model_step(input logic [7:0] op, input logic [7:0] imm);
        logic [8:0] sum;
        logic [7:0] res;
        case (op)
            OP_ASL: begin
                m_psr[`PSR_C] = m_acc[7];
                m_acc = {m_acc[6:0], 1'b0};
                set_nz(m_acc);
            end
            OP_LSR: begin
                m_psr[`PSR_C] = m_acc[0];
                m_acc = {1'b0, m_acc[7:1]};
                set_nz(m_acc);
            end
            OP_ROL: begin
                res = {m_acc[6:0], m_psr[`PSR_C]};
                m_psr[`PSR_C] = m_acc[7];
                m_acc = res;
                set_nz(m_acc);
            end
            OP_ROR: begin
                res = {m_psr[`PSR_C], m_acc[7:1]};
                m_psr[`PSR_C] = m_acc[0];
                m_acc = res;
                set_nz(m_acc);
            end
            OP_INX: begin
                m_x = m_x + 8'd1;
                set_nz(m_x);
            end
            OP_INY: begin
                m_y = m_y + 8'd1;
                set_nz(m_y);
            end
            OP_DEX: begin
                m_x = m_x - 8'd1;
                set_nz(m_x);
            end
            OP_DEY: begin
                m_y = m_y - 8'd1;
                set_nz(m_y);
            end
            OP_TAX: begin
                m_x = m_acc;
                set_nz(m_x);
            end
            OP_TAY: begin
                m_y = m_acc;
                set_nz(m_y);
            end
            OP_TXA: begin
                m_acc = m_x;
                set_nz(m_acc);
            end
            OP_TYA: begin
                m_acc = m_y;
                set_nz(m_acc);
            end
            OP_TSX: begin
                m_x = m_sp;
                set_nz(m_x);
            end
            OP_TXS: m_sp = m_x;
            OP_SEC: m_psr[`PSR_C] = 1'b1;
            OP_CLC: m_psr[`PSR_C] = 1'b0;
            OP_SED: m_psr[`PSR_D] = 1'b1;
            OP_CLD: m_psr[`PSR_D] = 1'b0;
            OP_SEI: m_psr[`PSR_I] = 1'b1;
            OP_CLI: m_psr[`PSR_I] = 1'b0;
            OP_CLV: m_psr[`PSR_V] = 1'b0;
            OP_ADC: begin
                sum = {1'b0, m_acc} + {1'b0, imm} + {8'h00, m_psr[`PSR_C]};
                // Signed overflow when both inputs share a sign the result lacks
                m_psr[`PSR_V] = ~(m_acc[7] ^ imm[7]) & (m_acc[7] ^ sum[7]);
                m_psr[`PSR_C] = sum[8];
                m_acc = sum[7:0];
                set_nz(m_acc);
            end
            OP_AND: begin
                m_acc = m_acc & imm;
                set_nz(m_acc);
            end
            // NOP and every unknown opcode
            default: ;
        endcase
    endtask

    task automatic check_byte(input string name, input string reg_name,
                              input logic [7:0] exp_val, input logic [7:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("** Error %s %s: expected %02h, actual %02h",
                     name, reg_name, exp_val, act_val);
        end
    endtask

    task automatic compare_regs(input string name);
        check_byte(name, "acc", m_acc, acc);
        check_byte(name, "x", m_x, idx_x);
        check_byte(name, "y", m_y, idx_y);
        check_byte(name, "sp", m_sp, sp);
        check_byte(name, "psr", m_psr, psr);
    endtask

    // One four-phase handshake, req held for extra cycles after ack
    task automatic run_op(input string name, input logic [7:0] op, input logic [7:0] imm,
                          input int hold);
        string tag;
        tag = $sformatf("%s op=%02h", name, op);
        @(posedge clk);
        req     <= 1'b1;
        opcode  <= op;
        operand <= imm;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        model_step(op, imm);
        compare_regs(tag);
        repeat (hold) begin
            @(negedge clk);
            if (!ack) begin
                errors++;
                $display("Error in %s: ack fell while req was still high", tag);
            end
            compare_regs(tag);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    // Expected PSR is the old value with just one bit forced
    task automatic flag_op(input logic [7:0] op, input logic [2:0] bit_pos,
                           input logic val);
        logic [7:0] exp_psr;
        exp_psr = m_psr;
        exp_psr[bit_pos] = val;
        run_op("flag", op, 8'h00, 0);
        check_byte($sformatf("flag op=%02h", op), "psr only", exp_psr, psr);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [7:0]  op;
        logic [7:0]  psr_before;
        int          hold;
        int          pick;

        req     = 1'b0;
        opcode  = 8'h00;
        operand = 8'h00;
        rst_n   = 1'b0;
        m_acc   = 8'h00;
        m_x     = 8'h00;
        m_y     = 8'h00;
        m_sp    = `T6502_SP_RESET;
        m_psr   = `T6502_PSR_RESET;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (ack) begin
            errors++;
            $display("Error in reset: ack is high after reset");
        end
        compare_regs("reset");

        // Every eighth transaction also holds req for 0 to 5 cycles after ack
        for (int i = 0; i < RAND_TXN; i++) begin
            rnd  = next_rand();
            pick = int'(rnd % 32'd24);
            hold = (i % 8 == 0) ? int'(rnd[18:16] % 3'd6) : 0;
            run_op("random", kept_ops[pick], rnd[15:8], hold);
        end

        // Transfers of a zero and a negative value
        run_op("transfer", OP_AND, 8'h00, 0);
        run_op("transfer", OP_TAX, 8'h00, 0);
        run_op("transfer", OP_CLC, 8'h00, 0);
        run_op("transfer", OP_ADC, 8'h9c, 0);
        run_op("transfer", OP_TAY, 8'h00, 0);
        run_op("transfer", OP_TXA, 8'h00, 0);
        run_op("transfer", OP_TYA, 8'h00, 0);
        run_op("transfer", OP_TSX, 8'h00, 0);
        run_op("transfer", OP_TAX, 8'h00, 0);
        // Flags show zero while X holds a negative value
        run_op("transfer", OP_AND, 8'h00, 0);
        psr_before = m_psr;
        run_op("transfer", OP_TXS, 8'h00, 0);
        check_byte("transfer op=9a", "psr kept", psr_before, psr);
        run_op("transfer", OP_TSX, 8'h00, 0);

        flag_op(OP_SEC, `PSR_C, 1'b1);
        flag_op(OP_CLC, `PSR_C, 1'b0);
        // D and I start from the opposite value of each tested write
        flag_op(OP_CLD, `PSR_D, 1'b0);
        flag_op(OP_SED, `PSR_D, 1'b1);
        flag_op(OP_CLD, `PSR_D, 1'b0);
        flag_op(OP_SEI, `PSR_I, 1'b1);
        flag_op(OP_CLI, `PSR_I, 1'b0);
        flag_op(OP_SEI, `PSR_I, 1'b1);
        // 7F plus 01 overflows, so CLV has a set V to clear
        run_op("flag", OP_AND, 8'h00, 0);
        run_op("flag", OP_ADC, 8'h7f, 0);
        run_op("flag", OP_ADC, 8'h01, 0);
        flag_op(OP_CLV, `PSR_V, 1'b0);

        for (int i = 0; i < UNKNOWN_TXN; i++) begin
            rnd = next_rand();
            op  = rnd[7:0];
            while (is_kept(op)) begin
                rnd = next_rand();
                op  = rnd[7:0];
            end
            run_op("unknown", op, rnd[15:8], 0);
        end

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
